// ==== verif/h80_cases.txt ====
// type addr data: 1 program word, 2 expected write, 3 end of case, 0 end of file
// case 0: zero and sign extended immediates
1 0000 117F 1 0002 1280 1 0004 2380 1 0006 1A80 1 0008 1B82 1 000A 1C84
1 000C 341A 1 000E 342B 1 0010 343C 1 0012 0001
2 0080 007F 2 0082 0080 2 0084 FF80
3 0000 0000
// case 1: alu results and flag word after add, sub, and, xor
1 0000 117F 1 0002 2280 1 0004 1A90 1 0006 1B92 1 0008 8312 1 000A 3D14
1 000C 343A 1 000E 344B 1 0010 9512 1 0012 3D14 1 0014 1A94 1 0016 1B96
1 0018 345A 1 001A 344B 1 001C C612 1 001E 3D14 1 0020 1A98 1 0022 1B9A
1 0024 346A 1 0026 344B 1 0028 D712 1 002A E812 1 002C 3D14 1 002E 1A9C
1 0030 1B9E 1 0032 1CA0 1 0034 347A 1 0036 348B 1 0038 344C 1 003A 0001
2 0090 FFFF 2 0092 0004 2 0094 00FF 2 0096 0002 2 0098 0000 2 009A 0009
2 009C FFFF 2 009E FFFF 2 00A0 000C
3 0000 0000
// case 2: compare sets zero and keeps its destination
1 0000 1105 1 0002 1205 1 0004 1333 1 0006 F312 1 0008 3D14 1 000A 1AA0
1 000C 1BA2 1 000E 343A 1 0010 344B 1 0012 0001
2 00A0 0033 2 00A2 0001
3 0000 0000
// case 3: jp z taken, jp c not taken, jp r, move to pc, jpn z not taken
1 0000 1105 1 0002 1AB0 1 0004 F011 1 0006 1D0C 1 0008 014D 1 000A 341A
1 000C 1D12 1 000E 015D 1 0010 341A 1 0012 1D18 1 0014 01ED 1 0016 341A
1 0018 1D1E 1 001A 3F0D 1 001C 341A 1 001E 010D 1 0020 1206 1 0022 1AB2
1 0024 342A 1 0026 0001
2 00B0 0005 2 00B2 0006
3 0000 0000
// case 4: word reads copied back by word writes
1 0000 1AC0 1 0002 1BC2 1 0004 1CD0 1 0006 1DD2 1 0008 321A 1 000A 322B
1 000C 341C 1 000E 342D 1 0010 8312 1 0012 1AD4 1 0014 343A 1 0016 0001
1 00C0 BEEF 1 00C2 1234
2 00D0 BEEF 2 00D2 1234 2 00D4 D123
3 0000 0000
// case 5: nop and a dropped mul encoding change nothing
1 0000 0000 1 0002 1105 1 0004 A111 1 0006 1AE0 1 0008 341A 1 000A 0001
2 00E0 0005
3 0000 0000
// case 6: halt at once, no writes
1 0000 0001
3 0000 0000
0 0000 0000

// ==== compile.f ====
hw/h80_pkg.sv
hw/h80_regfile.sv
hw/h80_alu.sv
hw/h80_branch.sv
hw/h80_control.sv
hw/h80_cpu.sv
verif/tb_clock.sv
verif/tb_h80_cpu.sv

// ==== Bender.yml ====
package:
  name: h80_cpu

sources:
  - hw/h80_pkg.sv
  - hw/h80_regfile.sv
  - hw/h80_alu.sv
  - hw/h80_branch.sv
  - hw/h80_control.sv
  - hw/h80_cpu.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/tb_h80_cpu.sv

// ==== verif/tb_h80_cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_h80_cpu import h80_pkg::*; ();

   localparam int REC_WORDS = 600;

   logic clk;
   logic por;
   logic case_rst;
   wire  reset = por | case_rst;
   wire  reg_t mem_addr;
   wire  mem_rd;
   wire  mem_wr;
   wire  reg_t mem_wdata;
   reg_t mem_rdata;
   logic mem_wait;
   wire  halted;

   reg_t   mem [256];
   reg_t   rec [REC_WORDS];                       // triples of type, address, data
   reg_t   got_addr[$];
   reg_t   got_data[$];
   reg_t   exp_addr[$];
   reg_t   exp_data[$];
   logic [31:0] lfsr;
   logic   in_xfer;
   int     waits_left;
   int     errors;
   int     case_count;
   int     bad_cases;

   tb_clock u_clock (.clk(clk), .reset(por));

   h80_cpu dut0 (
      .clk, .reset, .mem_addr, .mem_rd, .mem_wr, .mem_wdata, .mem_rdata, .mem_wait, .halted
   );

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic next_waits(output int n);
      logic [1:0] v;
      for (int i = 0; i < 2; i++) begin
         v[i] = lfsr[0];
         lfsr = lfsr_step(lfsr);                  // one step per bit
      end
      n = v % 3;
   endtask

   task automatic check_addr(input reg_t got, input reg_t exp, input string what);
      if (got !== exp) begin
         $display("ERROR %0t: %s address %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_data(input reg_t got, input reg_t exp, input string what);
      if (got !== exp) begin
         $display("ERROR %0t: %s data %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_halt(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
         errors++;
      end
   endtask

   // memory model, answers a little after each edge
   always begin
      @(posedge clk);
      #1;
      if (mem_rd || mem_wr) begin
         if (!in_xfer) begin
            in_xfer = 1'b1;
            next_waits(waits_left);
         end
         if (waits_left > 0) begin
            mem_wait = 1'b1;
            waits_left--;
         end else begin
            mem_wait  = 1'b0;
            mem_rdata = mem[mem_addr[8:1]];
            if (mem_wr) begin                     // completes at the coming edge
               mem[mem_addr[8:1]] = mem_wdata;
               got_addr.push_back(mem_addr);
               got_data.push_back(mem_wdata);
            end
            in_xfer = 1'b0;
         end
      end else begin
         mem_wait = 1'b0;
         in_xfer  = 1'b0;
      end
   end

   initial begin
      wait (case_count > 0);
      #(case_count * 400 * 10);
      $display("watchdog expired, the cases did not finish in time");
      $display("TEST FAIL");
      $finish;
   end

   initial begin
      int pos;
      int case_errs;
      int stray;
      mem_rdata  = '0;
      mem_wait   = 1'b0;
      case_rst   = 1'b0;
      in_xfer    = 1'b0;
      waits_left = 0;
      lfsr       = 32'd68483;
      errors     = 0;
      bad_cases  = 0;
      case_count = 0;
      $readmemh("verif/h80_cases.txt", rec);
      pos = 0;
      while (pos < REC_WORDS - 2 && rec[pos] !== 16'h0000 && rec[pos] !== 'x) begin
         if (rec[pos] == 16'h0003) begin
            case_count++;
         end
         pos += 3;
      end
      if (case_count == 0) begin
         $display("no cases found in the case file");
         errors++;
      end
      wait (!por);
      pos = 0;
      for (int c = 0; c < case_count; c++) begin
         case_errs = errors;
         stray     = 0;
         @(posedge clk);
         #1 case_rst = 1'b1;
         for (int i = 0; i < 256; i++) begin
            mem[i] = {~8'(i), 8'(i)};             // background pattern
         end
         exp_addr.delete();
         exp_data.delete();
         while (rec[pos] != 16'h0003) begin
            if (rec[pos] == 16'h0001) begin
               mem[rec[pos+1][8:1]] = rec[pos+2];
            end else begin
               exp_addr.push_back(rec[pos+1]);
               exp_data.push_back(rec[pos+2]);
            end
            pos += 3;
         end
         pos += 3;
         repeat (3) @(posedge clk);
         #1;
         got_addr.delete();
         got_data.delete();
         case_rst = 1'b0;
         #1;
         check_addr(mem_addr, RESET_ADDR, "first fetch");
         check_halt(mem_rd, 1'b1, "first fetch request");
         check_halt(halted, 1'b0, "halted after reset");
         while (halted !== 1'b1) @(posedge clk);
         repeat (8) begin
            @(posedge clk);
            #2;
            if (mem_rd || mem_wr) stray++;
         end
         check_halt(halted, 1'b1, "halted");
         if (stray != 0) begin
            $display("case %0d: bus requests seen after HALT", c);
            errors++;
         end
         if (got_addr.size() != exp_addr.size()) begin
            $display("case %0d: DUT made %0d memory writes, expected %0d",
                     c, got_addr.size(), exp_addr.size());
            errors++;
         end
         for (int i = 0; i < got_addr.size() && i < exp_addr.size(); i++) begin
            check_addr(got_addr[i], exp_addr[i], "write");
            check_data(got_data[i], exp_data[i], "write");
         end
         if (errors == case_errs) begin
            $display("case %0d: ok, %0d writes", c, got_addr.size());
         end else begin
            $display("case %0d: failed with %0d errors", c, errors - case_errs);
            bad_cases++;
         end
      end
      $display("cases run %0d, cases failed %0d, errors %0d", case_count, bad_cases, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
   output logic clk,
   output logic reset
);

   initial clk = 1'b0;
   always #5 clk = ~clk;                          // 10 ns period

   initial begin
      reset = 1'b1;
      repeat (3) @(posedge clk);
      #1 reset = 1'b0;
   end

endmodule

`default_nettype wire

// ==== hw/h80_cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module h80_cpu import h80_pkg::*; (
   input  wire       clk,
   input  wire       reset,
   output wire reg_t mem_addr,
   output wire       mem_rd,
   output wire       mem_wr,
   output wire reg_t mem_wdata,
   input  wire reg_t mem_rdata,
   input  wire       mem_wait,
   output wire       halted
);

   ins_t     ins;
   reg_num_t rd_a_num;
   reg_num_t rd_b_num;
   reg_t     rd_a;
   reg_t     rd_b;
   alu_op_t  alu_op;
   reg_t     result;
   flags_t   alu_flags;
   reg_t     next_pc;
   reg_t     pc;
   reg_t     flags;
   logic     wr_en;
   reg_num_t wr_num;
   reg_t     wr_data;
   logic     flags_en;
   logic     halt_set;
   logic     pc_en;
   reg_t     pc_in;

   h80_control u_control (
      .clk, .reset, .mem_rdata, .mem_wait, .mem_addr, .mem_rd, .mem_wr, .mem_wdata,
      .halted, .ins, .rd_a_num, .rd_b_num, .rd_a, .rd_b, .alu_op, .result,
      .alu_flags, .next_pc, .pc, .flags, .wr_en, .wr_num, .wr_data,
      .flags_en, .halt_set, .pc_en, .pc_in
   );

   h80_regfile u_regfile (
      .clk, .reset, .rd_a_num, .rd_b_num, .rd_a, .rd_b, .wr_en, .wr_num, .wr_data,
      .flags_en, .flags_in(alu_flags), .halt_set, .pc_en, .pc_in, .pc, .flags
   );

   h80_alu u_alu (
      .op(alu_op), .a(rd_a), .b(rd_b), .result, .flags_out(alu_flags)
   );

   h80_branch u_branch (
      .ins, .pc, .flags, .target(rd_b), .next_pc
   );

endmodule

`default_nettype wire

// ==== hw/h80_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module h80_control import h80_pkg::*; (
   input  wire      clk,
   input  wire      reset,
   input  wire      reg_t mem_rdata,
   input  wire      mem_wait,
   output reg_t     mem_addr,
   output logic     mem_rd,
   output logic     mem_wr,
   output reg_t     mem_wdata,
   output logic     halted,
   output ins_t     ins,
   output reg_num_t rd_a_num,
   output reg_num_t rd_b_num,
   input  wire      reg_t rd_a,
   input  wire      reg_t rd_b,
   output alu_op_t  alu_op,
   input  wire      reg_t result,
   input  wire      flags_t alu_flags,
   input  wire      reg_t next_pc,
   input  wire      reg_t pc,
   input  wire      reg_t flags,
   output logic     wr_en,
   output reg_num_t wr_num,
   output reg_t     wr_data,
   output logic     flags_en,
   output logic     halt_set,
   output logic     pc_en,
   output reg_t     pc_in
);

   cpu_state_t state;
   reg_num_t   rd_target;
   logic       fetch_done;
   logic       bus_done;
   logic       grp3;
   logic       bus_rd_ins;
   logic       bus_wr_ins;
   logic       mv_a_to_b;
   logic       mv_b_to_a;
   logic       is_halt;

   assign ins        = mem_rdata;                 // valid at fetch completion
   assign fetch_done = (state == S_FETCH_EXEC) && mem_rd && !mem_wait;
   assign bus_done   = (state == S_BUS_RW) && (mem_rd || mem_wr) && !mem_wait;
   assign halted     = flags[FLAG_HALT];

   assign grp3       = (ins[15:12] == OP_GRP3);
   assign bus_rd_ins = grp3 && (ins[11:9] == BUS_RD_W) && !ins[8];   // io form is a nop
   assign bus_wr_ins = grp3 && (ins[11:9] == BUS_WR_W) && !ins[8];
   assign mv_a_to_b  = grp3 && (ins[11:9] == MV_A_TO_B);
   assign mv_b_to_a  = grp3 && (ins[11:9] == MV_B_TO_A);
   assign is_halt    = (ins == INS_HALT);

   assign alu_op   = alu_op_t'(ins[15:12]);
   assign rd_b_num = {1'b0, ins[3:0]};           // address, jump target, move source
   assign rd_a_num = mv_a_to_b ? ins[8:4] : {1'b0, ins[7:4]};

   assign halt_set = fetch_done && is_halt;
   assign pc_en    = fetch_done;
   assign pc_in    = next_pc;

   // register write port source select
   always_comb begin
      wr_en    = 1'b0;
      wr_num   = {1'b0, ins[11:8]};
      wr_data  = result;
      flags_en = 1'b0;
      if (bus_done) begin
         wr_en   = mem_rd;
         wr_num  = rd_target;
         wr_data = mem_rdata;
      end else if (fetch_done) begin
         case (ins[15:12])
            OP_LD_ZX: begin
               wr_en   = 1'b1;
               wr_data = {{(REG_WIDTH-8){1'b0}}, ins[7:0]};
            end
            OP_LD_SX: begin
               wr_en   = 1'b1;
               wr_data = {{(REG_WIDTH-8){ins[7]}}, ins[7:0]};
            end
            OP_GRP3: begin
               if (mv_a_to_b) begin
                  wr_en   = 1'b1;
                  wr_num  = {1'b0, ins[3:0]};
                  wr_data = rd_a;
               end else if (mv_b_to_a) begin
                  wr_en   = 1'b1;                 // pc target handled by branch
                  wr_num  = ins[8:4];
                  wr_data = rd_b;
               end
            end
            default: begin
               if (ins[15]) begin
                  case (alu_op)
                     ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR: begin
                        wr_en    = 1'b1;
                        flags_en = 1'b1;
                     end
                     ALU_CP: flags_en = 1'b1;     // compare keeps dest
                     default: ;                   // mul/div slots
                  endcase
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= S_FETCH_EXEC;
         mem_rd   <= 1'b1;                        // first fetch right after reset
         mem_wr   <= 1'b0;
         mem_addr <= RESET_ADDR;
      end else if (fetch_done) begin
         if (is_halt) begin
            mem_rd <= 1'b0;
         end else if (bus_rd_ins || bus_wr_ins) begin
            state    <= S_BUS_RW;
            mem_rd   <= bus_rd_ins;
            mem_wr   <= bus_wr_ins;
            mem_addr <= rd_b;
         end else begin
            mem_addr <= next_pc;
         end
      end else if (bus_done) begin
         state    <= S_FETCH_EXEC;
         mem_rd   <= 1'b1;
         mem_wr   <= 1'b0;
         mem_addr <= pc;                          // already advanced at exec
      end
   end

   always_ff @(posedge clk) begin
      if (fetch_done) begin
         mem_wdata <= rd_a;
         rd_target <= {1'b0, ins[7:4]};
      end
   end

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
      !(mem_rd && mem_wr));

   a_bus_hold: assert property (@(posedge clk) disable iff (reset)
      mem_wait |=> $stable({mem_addr, mem_rd, mem_wr}) && (!mem_wr || $stable(mem_wdata)));

endmodule

`default_nettype wire

// ==== hw/h80_branch.sv ====
`timescale 1ns/1ns
`default_nettype none

module h80_branch import h80_pkg::*; (
   input  wire ins_t ins,
   input  wire reg_t pc,
   input  wire reg_t flags,
   input  wire reg_t target,
   output reg_t      next_pc
);

   logic taken;
   logic mv_to_pc;

   // only the 5-bit destination form of the move can reach the pc
   assign mv_to_pc = (ins[15:12] == OP_GRP3) && (ins[11:9] == MV_B_TO_A) &&
                     (ins[8:4] == REG_PC);

   always_comb begin
      taken = 1'b0;
      if (ins[15:4] == OP_JP_R) begin
         taken = 1'b1;
      end else if (ins[15:7] == OP_JP_COND) begin
         taken = (flags[ins[5:4]] == ins[6]);      // JP on set, JPN on clear
      end else if (mv_to_pc) begin
         taken = 1'b1;
      end
   end

   assign next_pc = taken ? target : pc + INS_BYTES;

endmodule

`default_nettype wire

// ==== hw/h80_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module h80_alu import h80_pkg::*; (
   input  var  alu_op_t op,
   input  wire reg_t    a,
   input  wire reg_t    b,
   output reg_t         result,
   output flags_t       flags_out
);

   logic [REG_WIDTH:0] a_x;
   logic [REG_WIDTH:0] b_x;
   logic [REG_WIDTH:0] sum;
   logic               arith;
   logic               ovf;

   always_comb begin
      a_x   = {1'b0, a};
      b_x   = {1'b0, b};
      arith = 1'b1;
      case (op)
         ALU_ADD: sum = a_x + b_x;
         ALU_SUB, ALU_CP: sum = a_x - b_x;        // bit 16 holds the borrow
         ALU_AND: begin
            sum   = a_x & b_x;
            arith = 1'b0;
         end
         ALU_OR: begin
            sum   = a_x | b_x;
            arith = 1'b0;
         end
         ALU_XOR: begin
            sum   = a_x ^ b_x;
            arith = 1'b0;
         end
         default: begin
            sum   = '0;
            arith = 1'b0;
         end
      endcase

      if (!arith) begin
         ovf = ~^sum[REG_WIDTH-1:0];              // even parity on logic ops
      end else if (op == ALU_ADD) begin
         ovf = (a[REG_WIDTH-1] == b[REG_WIDTH-1]) && (sum[REG_WIDTH-1] != a[REG_WIDTH-1]);
      end else begin
         ovf = (a[REG_WIDTH-1] != b[REG_WIDTH-1]) && (sum[REG_WIDTH-1] != a[REG_WIDTH-1]);
      end

      flags_out[FLAG_ZERO]     = (sum[REG_WIDTH-1:0] == '0);
      flags_out[FLAG_CARRY]    = arith & sum[REG_WIDTH];
      flags_out[FLAG_SIGN]     = sum[REG_WIDTH-1];
      flags_out[FLAG_OVERFLOW] = ovf;
   end

   assign result = sum[REG_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== hw/h80_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module h80_regfile import h80_pkg::*; (
   input  wire      clk,
   input  wire      reset,
   input  wire      reg_num_t rd_a_num,
   input  wire      reg_num_t rd_b_num,
   output reg_t     rd_a,
   output reg_t     rd_b,
   input  wire      wr_en,
   input  wire      reg_num_t wr_num,
   input  wire      reg_t wr_data,
   input  wire      flags_en,
   input  wire      flags_t flags_in,
   input  wire      halt_set,
   input  wire      pc_en,
   input  wire      reg_t pc_in,
   output reg_t     pc,
   output reg_t     flags
);

   reg_t gpr [16];
   reg_t pc_q;
   reg_t flag_q;
   reg_t flag_nxt;

   function automatic reg_t read_reg(reg_num_t num);
      reg_t val;
      if (num == REG_PC) begin
         val = pc_q;
      end else if (num == REG_FLAG) begin
         val = flag_q;
      end else if (num < NUM_REGS) begin
         val = gpr[num[3:0]];
      end else begin
         val = '0;                                // unused numbers read as zero
      end
      return val;
   endfunction

   always_comb begin
      rd_a = read_reg(rd_a_num);
      rd_b = read_reg(rd_b_num);
   end

   // flag port beats a general write to 17
   always_comb begin
      flag_nxt = flag_q;
      if (wr_en && wr_num == REG_FLAG) begin
         flag_nxt = wr_data;
      end
      if (flags_en) begin
         flag_nxt = {flag_q[REG_WIDTH-1:FLAG_OVERFLOW+1], flags_in};
      end
      if (halt_set) begin
         flag_nxt[FLAG_HALT] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 16; i++) begin
            gpr[i] <= '0;
         end
         pc_q   <= RESET_ADDR;
         flag_q <= '0;
      end else begin
         if (wr_en && wr_num < REG_PC) begin
            gpr[wr_num[3:0]] <= wr_data;          // write to 16 is dropped here
         end
         if (pc_en) begin
            pc_q <= pc_in;
         end
         flag_q <= flag_nxt;
      end
   end

   assign pc    = pc_q;
   assign flags = flag_q;

   a_wr_num_range: assert property (@(posedge clk) disable iff (reset)
      wr_en |-> wr_num < NUM_REGS);

endmodule

`default_nettype wire

// ==== hw/h80_pkg.sv ====
`default_nettype none

package h80_pkg;

   localparam int REG_WIDTH = 16;
   localparam int NUM_REGS  = 18;                  // 16 general + pc + flags

   typedef logic [REG_WIDTH-1:0] reg_t;
   typedef logic [4:0]           reg_num_t;
   typedef logic [15:0]          ins_t;
   typedef logic [3:0]           flags_t;          // zero, carry, sign, overflow

   localparam reg_num_t REG_PC   = 5'd16;
   localparam reg_num_t REG_FLAG = 5'd17;

   localparam reg_t INS_BYTES  = 16'd2;
   localparam reg_t RESET_ADDR = 16'h0000;

   localparam int FLAG_ZERO     = 0;
   localparam int FLAG_CARRY    = 1;
   localparam int FLAG_SIGN     = 2;
   localparam int FLAG_OVERFLOW = 3;
   localparam int FLAG_HALT     = 15;

   // top nibble of the three-register group
   typedef enum logic [3:0] {
      ALU_ADD = 4'h8,
      ALU_SUB = 4'h9,
      ALU_AND = 4'hC,
      ALU_OR  = 4'hD,
      ALU_XOR = 4'hE,
      ALU_CP  = 4'hF
   } alu_op_t;

   typedef enum logic {
      S_FETCH_EXEC,
      S_BUS_RW
   } cpu_state_t;

   localparam ins_t        INS_HALT   = 16'h0001;
   localparam logic [11:0] OP_JP_R    = 12'h01E;      // ins[15:4]
   localparam logic [8:0]  OP_JP_COND = 9'b0000_0001_0; // ins[15:7], ins[6] is polarity
   localparam logic [3:0]  OP_LD_ZX   = 4'h1;
   localparam logic [3:0]  OP_LD_SX   = 4'h2;
   localparam logic [3:0]  OP_GRP3    = 4'h3;         // bus transfers and moves

   // ins[11:9] inside group 3
   localparam logic [2:0] BUS_RD_W  = 3'd1;
   localparam logic [2:0] BUS_WR_W  = 3'd2;
   localparam logic [2:0] MV_A_TO_B = 3'b110;
   localparam logic [2:0] MV_B_TO_A = 3'b111;

endpackage

`default_nettype wire
